//--- verilog/mem_cfg_pkg.sv
package mem_cfg_pkg;

  // data word
  localparam int width = 16;

  // logical address space, not a power of two
  localparam int num_addr = 48;
  localparam int bit_addr = 6;

  // data banks, the spare bank sits at index num_vbnk
  localparam int num_vbnk = 3;
  localparam int bit_vbnk = 2;
  localparam int num_pbnk = num_vbnk + 1;
  localparam logic [bit_vbnk-1:0] spare_bnk = bit_vbnk'(num_vbnk);

  // rows per bank
  localparam int num_vrow = 16;
  localparam int bit_vrow = 4;

  // physical address is {bank, row}
  localparam int bit_padr = bit_vbnk + bit_vrow;

  // enough bits to count every flagged bank on one row
  localparam int bit_fcnt = $clog2(num_pbnk + 1);

  // result pipeline depth and strobe-to-valid latency
  localparam int mem_delay = 2;
  localparam int rd_latency = mem_delay + 2;

endpackage

//--- verilog/mem_op_pkg.sv
package mem_op_pkg;

  // write port opcode
  // op_inject_err flags the addressed bank at the addressed row,
  // op_inject_spare flags the spare bank at that row instead
  typedef enum logic [1:0] {
    op_idle         = 2'd0,
    op_write        = 2'd1,
    op_inject_err   = 2'd2,
    op_inject_spare = 2'd3
  } mem_op_e;

  // read error status, derived from the flag count on the read row
  typedef enum logic [1:0] {
    // no flagged bank
    st_ok     = 2'd0,
    // exactly one flagged bank
    st_single = 2'd1,
    // two or more
    st_double = 2'd2
  } err_status_e;

endpackage

//--- verilog/mem_req_if.sv
`timescale 1ns/1ns

// decoded requests, one cycle after the port sample
interface mem_req_if;

  // read side, rd_bank and rd_row only meaningful while rd_en is high
  logic                              rd_en;
  logic [mem_cfg_pkg::bit_vbnk-1:0]  rd_bank;
  logic [mem_cfg_pkg::bit_vrow-1:0]  rd_row;

  // write side, payload only meaningful while wr_op is not idle
  mem_op_pkg::mem_op_e               wr_op;
  logic [mem_cfg_pkg::bit_vbnk-1:0]  wr_bank;
  logic [mem_cfg_pkg::bit_vrow-1:0]  wr_row;
  logic [mem_cfg_pkg::width-1:0]     wr_data;

  modport decode (
    output rd_en, rd_bank, rd_row,
    output wr_op, wr_bank, wr_row, wr_data
  );

  modport exec (
    input rd_en, rd_bank, rd_row,
    input wr_op, wr_bank, wr_row, wr_data
  );

endinterface

//--- verilog/rd_result_if.sv
`timescale 1ns/1ns

// raw read result, vld is a one-cycle strobe per read
interface rd_result_if;

  logic                              vld;
  logic [mem_cfg_pkg::width-1:0]     data;
  logic                              serr;
  logic                              derr;
  // {bank, row} of the decoded or the flagged location
  logic [mem_cfg_pkg::bit_padr-1:0]  padr;

  modport exec (
    output vld, data, serr, derr, padr
  );

  modport pipe (
    input vld, data, serr, derr, padr
  );

endinterface

//--- verilog/req_decode.sv
`timescale 1ns/1ns

module req_decode (
  input  logic                              clk,
  input  logic                              rst,
  input  logic                              rd,
  input  logic [mem_cfg_pkg::bit_addr-1:0]  rd_addr,
  input  mem_op_pkg::mem_op_e               wr_op,
  input  logic [mem_cfg_pkg::bit_addr-1:0]  wr_addr,
  input  logic [mem_cfg_pkg::width-1:0]     wr_data,
  mem_req_if.decode                         req
);

  // address to {bank, row}
  // bank is addr mod num_vbnk, row is addr div num_vbnk
  function automatic logic [mem_cfg_pkg::bit_padr-1:0] split_addr(
      input logic [mem_cfg_pkg::bit_addr-1:0] addr);
    int quo;
    int rem;
    quo = int'(addr) / mem_cfg_pkg::num_vbnk;
    rem = int'(addr) % mem_cfg_pkg::num_vbnk;
    return {rem[mem_cfg_pkg::bit_vbnk-1:0], quo[mem_cfg_pkg::bit_vrow-1:0]};
  endfunction

  logic [mem_cfg_pkg::bit_padr-1:0] rd_split;
  logic [mem_cfg_pkg::bit_padr-1:0] wr_split;
  logic [mem_cfg_pkg::bit_vbnk-1:0] wr_bank_c;

  assign rd_split = split_addr(rd_addr);
  assign wr_split = split_addr(wr_addr);

  // spare injection ignores the decoded bank, keeps the row
  always_comb begin
    case (wr_op)
      mem_op_pkg::op_inject_spare: begin
        wr_bank_c = mem_cfg_pkg::spare_bnk;
      end
      default: begin
        wr_bank_c = wr_split[mem_cfg_pkg::bit_padr-1 -: mem_cfg_pkg::bit_vbnk];
      end
    endcase
  end

  // request strobes
  always_ff @(posedge clk) begin
    if (rst) begin
      req.rd_en <= 1'b0;
      req.wr_op <= mem_op_pkg::op_idle;
    end else begin
      req.rd_en <= rd;
      req.wr_op <= wr_op;
    end
  end

  // read payload, held while idle
  always_ff @(posedge clk) begin
    if (rd) begin
      req.rd_bank <= rd_split[mem_cfg_pkg::bit_padr-1 -: mem_cfg_pkg::bit_vbnk];
      req.rd_row  <= rd_split[mem_cfg_pkg::bit_vrow-1:0];
    end
  end

  // write payload
  always_ff @(posedge clk) begin
    if (wr_op != mem_op_pkg::op_idle) begin
      req.wr_bank <= wr_bank_c;
      req.wr_row  <= wr_split[mem_cfg_pkg::bit_vrow-1:0];
      req.wr_data <= wr_data;
    end
  end

endmodule

//--- verilog/bank_array_exec.sv
`timescale 1ns/1ns

module bank_array_exec (
  input  logic        clk,
  input  logic        rst,
  mem_req_if.exec     req,
  rd_result_if.exec   res
);

  // data storage, bank by row
  logic [mem_cfg_pkg::width-1:0] mem_data [mem_cfg_pkg::num_vbnk][mem_cfg_pkg::num_vrow];

  // error flags, one vector per row with a bit for every bank and the spare
  logic [mem_cfg_pkg::num_pbnk-1:0] err_flag [mem_cfg_pkg::num_vrow];

  // read side flag evaluation
  logic [mem_cfg_pkg::num_pbnk-1:0] rd_flags;
  logic [mem_cfg_pkg::bit_fcnt-1:0] flag_cnt;
  logic [mem_cfg_pkg::bit_vbnk-1:0] flag_bnk;
  mem_op_pkg::err_status_e          rd_status;

  // data write, injections leave the data untouched
  always_ff @(posedge clk) begin
    if (req.wr_op == mem_op_pkg::op_write) begin
      mem_data[req.wr_bank][req.wr_row] <= req.wr_data;
    end
  end

  // flag map
  always_ff @(posedge clk) begin
    if (rst) begin
      for (int r = 0; r < mem_cfg_pkg::num_vrow; r++) begin
        err_flag[r] <= '0;
      end
    end else begin
      case (req.wr_op)
        mem_op_pkg::op_write: begin
          // a fresh write repairs the location and releases the spare
          err_flag[req.wr_row][req.wr_bank]            <= 1'b0;
          err_flag[req.wr_row][mem_cfg_pkg::spare_bnk] <= 1'b0;
        end
        mem_op_pkg::op_inject_err,
        mem_op_pkg::op_inject_spare: begin
          // bank already points at the spare for op_inject_spare
          err_flag[req.wr_row][req.wr_bank] <= 1'b1;
        end
        default: ;
      endcase
    end
  end

  // count flagged banks on the read row
  // descending scan so flag_bnk ends on the lowest flagged bank
  always_comb begin
    rd_flags = err_flag[req.rd_row];
    flag_cnt = '0;
    flag_bnk = '0;
    for (int b = mem_cfg_pkg::num_pbnk - 1; b >= 0; b--) begin
      if (rd_flags[b]) begin
        flag_cnt++;
        flag_bnk = b[mem_cfg_pkg::bit_vbnk-1:0];
      end
    end
  end

  always_comb begin
    if (flag_cnt == 0) begin
      rd_status = mem_op_pkg::st_ok;
    end else if (flag_cnt == 1) begin
      rd_status = mem_op_pkg::st_single;
    end else begin
      rd_status = mem_op_pkg::st_double;
    end
  end

  // result strobe
  always_ff @(posedge clk) begin
    if (rst) begin
      res.vld <= 1'b0;
    end else begin
      res.vld <= req.rd_en;
    end
  end

  // result payload
  // array is read before this edge's write lands, so same-cycle writes are not seen
  always_ff @(posedge clk) begin
    if (req.rd_en) begin
      res.data <= mem_data[req.rd_bank][req.rd_row];
      res.serr <= (rd_status != mem_op_pkg::st_ok);
      res.derr <= (rd_status == mem_op_pkg::st_double);
      if (rd_status == mem_op_pkg::st_ok) begin
        res.padr <= {req.rd_bank, req.rd_row};
      end else begin
        res.padr <= {flag_bnk, req.rd_row};
      end
    end
  end

endmodule

//--- verilog/read_result_pipe.sv
`timescale 1ns/1ns

module read_result_pipe #(
  parameter int depth = mem_cfg_pkg::mem_delay
) (
  input  logic                              clk,
  input  logic                              rst,
  rd_result_if.pipe                         res,
  output logic                              rd_vld,
  output logic [mem_cfg_pkg::width-1:0]     rd_data,
  output logic                              rd_serr,
  output logic                              rd_derr,
  output logic [mem_cfg_pkg::bit_padr-1:0]  rd_padr
);

  // stage 0 takes the raw result, stage depth-1 drives the ports
  logic                             vld_q  [depth];
  logic [mem_cfg_pkg::width-1:0]    data_q [depth];
  logic                             serr_q [depth];
  logic                             derr_q [depth];
  logic [mem_cfg_pkg::bit_padr-1:0] padr_q [depth];

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < depth; i++) begin
        vld_q[i] <= 1'b0;
      end
    end else begin
      vld_q[0] <= res.vld;
      for (int i = 1; i < depth; i++) begin
        vld_q[i] <= vld_q[i-1];
      end
    end
  end

  // payload shifts freely, only meaningful alongside its valid
  always_ff @(posedge clk) begin
    data_q[0] <= res.data;
    serr_q[0] <= res.serr;
    derr_q[0] <= res.derr;
    padr_q[0] <= res.padr;
    for (int i = 1; i < depth; i++) begin
      data_q[i] <= data_q[i-1];
      serr_q[i] <= serr_q[i-1];
      derr_q[i] <= derr_q[i-1];
      padr_q[i] <= padr_q[i-1];
    end
  end

  assign rd_vld  = vld_q[depth-1];
  assign rd_data = data_q[depth-1];
  assign rd_serr = serr_q[depth-1];
  assign rd_derr = derr_q[depth-1];
  assign rd_padr = padr_q[depth-1];

endmodule

//--- verilog/mem_1r1w_top.sv
`timescale 1ns/1ns

module mem_1r1w_top (
  input  logic                              clk,
  input  logic                              rst,

  // read port
  input  logic                              rd,
  input  logic [mem_cfg_pkg::bit_addr-1:0]  rd_addr,

  // write port
  input  mem_op_pkg::mem_op_e               wr_op,
  input  logic [mem_cfg_pkg::bit_addr-1:0]  wr_addr,
  input  logic [mem_cfg_pkg::width-1:0]     wr_data,

  // read result, rd_latency cycles after rd
  output logic                              rd_vld,
  output logic [mem_cfg_pkg::width-1:0]     rd_data,
  output logic                              rd_serr,
  output logic                              rd_derr,
  output logic [mem_cfg_pkg::bit_padr-1:0]  rd_padr
);

  // decode to execute
  mem_req_if u_req_if ();

  // execute to result pipeline
  rd_result_if u_res_if ();

  // port sample and address split
  req_decode u_decode (
    .clk     (clk),
    .rst     (rst),
    .rd      (rd),
    .rd_addr (rd_addr),
    .wr_op   (wr_op),
    .wr_addr (wr_addr),
    .wr_data (wr_data),
    .req     (u_req_if.decode)
  );

  // array access and flag tracking
  bank_array_exec u_exec (
    .clk (clk),
    .rst (rst),
    .req (u_req_if.exec),
    .res (u_res_if.exec)
  );

  // output delay
  read_result_pipe #(
    .depth (mem_cfg_pkg::mem_delay)
  ) u_pipe (
    .clk     (clk),
    .rst     (rst),
    .res     (u_res_if.pipe),
    .rd_vld  (rd_vld),
    .rd_data (rd_data),
    .rd_serr (rd_serr),
    .rd_derr (rd_derr),
    .rd_padr (rd_padr)
  );

endmodule

//--- test/mem_1r1w_chk.sv
`timescale 1ns/1ns

module mem_1r1w_chk (
  input logic clk,
  input logic rst,
  input logic rd,
  input logic rd_vld,
  input logic rd_serr,
  input logic rd_derr
);

  // number of failed assertions, read by the testbench at the end
  int fail_cnt = 0;

  // every read strobe returns one valid after the fixed latency
  a_rd_to_vld: assert property (@(posedge clk) disable iff (rst)
    rd |-> ##(mem_cfg_pkg::rd_latency) rd_vld)
    else begin
      $error("read strobe without a valid %0d cycles later", mem_cfg_pkg::rd_latency);
      fail_cnt++;
    end

  // and no valid appears without a read behind it
  a_vld_from_rd: assert property (@(posedge clk) disable iff (rst)
    rd_vld |-> $past(rd, mem_cfg_pkg::rd_latency))
    else begin
      $error("read valid without a matching read strobe");
      fail_cnt++;
    end

  // double error is always reported as a single error too
  a_derr_has_serr: assert property (@(posedge clk) disable iff (rst)
    (rd_vld && rd_derr) |-> rd_serr)
    else begin
      $error("rd_derr set while rd_serr is clear");
      fail_cnt++;
    end

  // one edge into reset the pipeline valid is already cleared
  a_no_vld_in_rst: assert property (@(posedge clk)
    (rst ##1 rst) |-> !rd_vld)
    else begin
      $error("rd_vld high during reset");
      fail_cnt++;
    end

endmodule

//--- test/mem_1r1w_scoreboard.sv
`timescale 1ns/1ns

module mem_1r1w_scoreboard (
  input  logic                              clk,
  input  logic                              rst,
  // expectation strobe, one per read issued
  input  logic                              exp_vld,
  input  logic [mem_cfg_pkg::width-1:0]     exp_data,
  input  logic                              exp_serr,
  input  logic                              exp_derr,
  input  logic [mem_cfg_pkg::bit_padr-1:0]  exp_padr,
  // DUT read result
  input  logic                              rd_vld,
  input  logic [mem_cfg_pkg::width-1:0]     rd_data,
  input  logic                              rd_serr,
  input  logic                              rd_derr,
  input  logic [mem_cfg_pkg::bit_padr-1:0]  rd_padr,
  output int                                mismatch_cnt,
  output int                                unexpected_cnt,
  output int                                pending
);

  typedef struct packed {
    logic [mem_cfg_pkg::width-1:0]    data;
    logic                             serr;
    logic                             derr;
    logic [mem_cfg_pkg::bit_padr-1:0] padr;
  } exp_t;

  exp_t exp_q[$];
  exp_t cur;

  task automatic compare_field(input string name, input logic [31:0] exp_val,
                               input logic [31:0] act_val);
    if (act_val !== exp_val) begin
      $display("FAILED time %0t signal %s expected %0h actual %0h",
               $time, name, exp_val, act_val);
      mismatch_cnt++;
    end
  endtask

  // results come back in issue order, so a plain queue is enough
  always @(posedge clk) begin
    if (rst) begin
      exp_q.delete();
      mismatch_cnt = 0;
      unexpected_cnt = 0;
    end else begin
      if (exp_vld) begin
        exp_q.push_back({exp_data, exp_serr, exp_derr, exp_padr});
      end
      if (rd_vld) begin
        if (exp_q.size() == 0) begin
          $display("read valid at time %0t with no read outstanding", $time);
          unexpected_cnt++;
        end else begin
          cur = exp_q.pop_front();
          compare_field("rd_data", 32'(cur.data), 32'(rd_data));
          compare_field("rd_serr", 32'(cur.serr), 32'(rd_serr));
          compare_field("rd_derr", 32'(cur.derr), 32'(rd_derr));
          compare_field("rd_padr", 32'(cur.padr), 32'(rd_padr));
        end
      end
    end
    pending = exp_q.size();
  end

endmodule

//--- test/mem_1r1w_tb.sv
`timescale 1ns/1ns

module mem_1r1w_tb;

  // one row per cycle with port activity and what a read there must return
  typedef struct packed {
    logic                              rd;
    logic [mem_cfg_pkg::bit_addr-1:0]  rd_addr;
    mem_op_pkg::mem_op_e               wr_op;
    logic [mem_cfg_pkg::bit_addr-1:0]  wr_addr;
    logic [mem_cfg_pkg::width-1:0]     wr_data;
    logic [mem_cfg_pkg::width-1:0]     exp_data;
    logic                              exp_serr;
    logic                              exp_derr;
    logic [mem_cfg_pkg::bit_padr-1:0]  exp_padr;
  } stim_row_t;

  localparam int drain_limit = 64;

  logic                              clk = 1'b0;
  logic                              rst;
  logic                              rd;
  logic [mem_cfg_pkg::bit_addr-1:0]  rd_addr;
  mem_op_pkg::mem_op_e               wr_op;
  logic [mem_cfg_pkg::bit_addr-1:0]  wr_addr;
  logic [mem_cfg_pkg::width-1:0]     wr_data;
  logic                              rd_vld;
  logic [mem_cfg_pkg::width-1:0]     rd_data;
  logic                              rd_serr;
  logic                              rd_derr;
  logic [mem_cfg_pkg::bit_padr-1:0]  rd_padr;

  logic                              exp_vld;
  logic [mem_cfg_pkg::width-1:0]     exp_data;
  logic                              exp_serr;
  logic                              exp_derr;
  logic [mem_cfg_pkg::bit_padr-1:0]  exp_padr;

  int mismatch_cnt;
  int unexpected_cnt;
  int pending;
  int timeout_cnt;
  int assert_cnt;
  int waited;
  stim_row_t table_q[$];

  always #20 clk = ~clk;

  mem_1r1w_top u_dut (
    .clk     (clk),
    .rst     (rst),
    .rd      (rd),
    .rd_addr (rd_addr),
    .wr_op   (wr_op),
    .wr_addr (wr_addr),
    .wr_data (wr_data),
    .rd_vld  (rd_vld),
    .rd_data (rd_data),
    .rd_serr (rd_serr),
    .rd_derr (rd_derr),
    .rd_padr (rd_padr)
  );

  mem_1r1w_scoreboard u_sb (
    .clk            (clk),
    .rst            (rst),
    .exp_vld        (exp_vld),
    .exp_data       (exp_data),
    .exp_serr       (exp_serr),
    .exp_derr       (exp_derr),
    .exp_padr       (exp_padr),
    .rd_vld         (rd_vld),
    .rd_data        (rd_data),
    .rd_serr        (rd_serr),
    .rd_derr        (rd_derr),
    .rd_padr        (rd_padr),
    .mismatch_cnt   (mismatch_cnt),
    .unexpected_cnt (unexpected_cnt),
    .pending        (pending)
  );

  bind mem_1r1w_top mem_1r1w_chk u_chk (
    .clk     (clk),
    .rst     (rst),
    .rd      (rd),
    .rd_vld  (rd_vld),
    .rd_serr (rd_serr),
    .rd_derr (rd_derr)
  );

  // initial contents use every address bit twice
  function automatic logic [15:0] data_pattern(input logic [5:0] a);
    return {4'hc, a, ~a};
  endfunction

  task automatic queue_row(input logic r, input logic [5:0] ra, input mem_op_pkg::mem_op_e op,
                           input logic [5:0] wa, input logic [15:0] wd, input logic [15:0] ed,
                           input logic es, input logic ee, input int eb, input int er);
    stim_row_t row;
    row.rd       = r;
    row.rd_addr  = ra;
    row.wr_op    = op;
    row.wr_addr  = wa;
    row.wr_data  = wd;
    row.exp_data = ed;
    row.exp_serr = es;
    row.exp_derr = ee;
    row.exp_padr = {eb[mem_cfg_pkg::bit_vbnk-1:0], er[mem_cfg_pkg::bit_vrow-1:0]};
    table_q.push_back(row);
  endtask

  task automatic queue_write(input mem_op_pkg::mem_op_e op, input logic [5:0] wa,
                             input logic [15:0] wd);
    queue_row(1'b0, '0, op, wa, wd, '0, 1'b0, 1'b0, 0, 0);
  endtask

  task automatic queue_read(input logic [5:0] ra, input logic [15:0] ed, input logic es,
                            input logic ee, input int eb, input int er);
    queue_row(1'b1, ra, mem_op_pkg::op_idle, '0, '0, ed, es, ee, eb, er);
  endtask

  task automatic build_table();
    int eb;
    int er;
    // fill every address, then read all back to back
    for (int a = 0; a < mem_cfg_pkg::num_addr; a++) begin
      queue_write(mem_op_pkg::op_write, 6'(a), data_pattern(6'(a)));
    end
    // consecutive addresses walk the banks of a row before the next row starts
    eb = 0;
    er = 0;
    for (int a = 0; a < mem_cfg_pkg::num_addr; a++) begin
      queue_read(6'(a), data_pattern(6'(a)), 1'b0, 1'b0, eb, er);
      if (eb == mem_cfg_pkg::num_vbnk - 1) begin
        eb = 0;
        er++;
      end else begin
        eb++;
      end
    end
    // addr 7 is bank 1 row 2 and its row neighbours see the same flag
    queue_write(mem_op_pkg::op_inject_err, 6'd7, 16'h0);
    queue_read(6'd7, data_pattern(6'd7), 1'b1, 1'b0, 1, 2);
    queue_read(6'd6, data_pattern(6'd6), 1'b1, 1'b0, 1, 2);
    queue_read(6'd8, data_pattern(6'd8), 1'b1, 1'b0, 1, 2);
    // row 5 gets bank 2 plus the spare
    queue_write(mem_op_pkg::op_inject_err, 6'd17, 16'h0);
    queue_write(mem_op_pkg::op_inject_spare, 6'd15, 16'h0);
    queue_read(6'd16, data_pattern(6'd16), 1'b1, 1'b1, 2, 5);
    queue_read(6'd15, data_pattern(6'd15), 1'b1, 1'b1, 2, 5);
    // rewrite of bank 2 clears both flags on row 5
    queue_write(mem_op_pkg::op_write, 6'd17, 16'hbeef);
    queue_read(6'd17, 16'hbeef, 1'b0, 1'b0, 2, 5);
    queue_read(6'd16, data_pattern(6'd16), 1'b0, 1'b0, 1, 5);
    // row 2 ends up with banks 1, 2 and spare flagged
    queue_write(mem_op_pkg::op_inject_spare, 6'd6, 16'h0);
    queue_write(mem_op_pkg::op_inject_err, 6'd8, 16'h0);
    queue_read(6'd6, data_pattern(6'd6), 1'b1, 1'b1, 1, 2);
    // rewrite of bank 1 leaves only bank 2
    queue_write(mem_op_pkg::op_write, 6'd7, 16'h1234);
    queue_read(6'd7, 16'h1234, 1'b1, 1'b0, 2, 2);
    queue_read(6'd8, data_pattern(6'd8), 1'b1, 1'b0, 2, 2);
    // addr 20 is bank 2 row 6 and the same-cycle read sees the old word
    queue_row(1'b1, 6'd20, mem_op_pkg::op_write, 6'd20, 16'h5a5a,
              data_pattern(6'd20), 1'b0, 1'b0, 2, 6);
    queue_read(6'd20, 16'h5a5a, 1'b0, 1'b0, 2, 6);
  endtask

  initial begin
    rst = 1'b1;
    rd = 1'b0;
    rd_addr = '0;
    wr_op = mem_op_pkg::op_idle;
    wr_addr = '0;
    wr_data = '0;
    exp_vld = 1'b0;
    exp_data = '0;
    exp_serr = 1'b0;
    exp_derr = 1'b0;
    exp_padr = '0;
    timeout_cnt = 0;
    build_table();
    repeat (16) @(posedge clk);
    rst <= 1'b0;
    foreach (table_q[i]) begin
      @(posedge clk);
      rd       <= table_q[i].rd;
      rd_addr  <= table_q[i].rd_addr;
      wr_op    <= table_q[i].wr_op;
      wr_addr  <= table_q[i].wr_addr;
      wr_data  <= table_q[i].wr_data;
      exp_vld  <= table_q[i].rd;
      exp_data <= table_q[i].exp_data;
      exp_serr <= table_q[i].exp_serr;
      exp_derr <= table_q[i].exp_derr;
      exp_padr <= table_q[i].exp_padr;
    end
    @(posedge clk);
    rd      <= 1'b0;
    wr_op   <= mem_op_pkg::op_idle;
    exp_vld <= 1'b0;
    // drain outstanding reads
    waited = 0;
    @(negedge clk);
    while (pending != 0 && waited < drain_limit) begin
      @(negedge clk);
      waited++;
    end
    if (pending != 0) begin
      $display("timeout: %0d reads still outstanding after %0d cycles", pending, waited);
      timeout_cnt++;
    end
    // room for any stray valid to show up
    repeat (mem_cfg_pkg::rd_latency + 2) @(negedge clk);
    assert_cnt = u_dut.u_chk.fail_cnt;
    $display("errors: mismatch %0d, unexpected valid %0d, timeout %0d, assertion %0d",
             mismatch_cnt, unexpected_cnt, timeout_cnt, assert_cnt);
    if (mismatch_cnt + unexpected_cnt + timeout_cnt + assert_cnt == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

endmodule

//--- build.f
verilog/mem_cfg_pkg.sv
verilog/mem_op_pkg.sv
verilog/mem_req_if.sv
verilog/rd_result_if.sv
verilog/req_decode.sv
verilog/bank_array_exec.sv
verilog/read_result_pipe.sv
verilog/mem_1r1w_top.sv
test/mem_1r1w_chk.sv
test/mem_1r1w_scoreboard.sv
test/mem_1r1w_tb.sv
